// File: design/gf3m_config.svh
`ifndef GF3M_CONFIG_SVH
`define GF3M_CONFIG_SVH

// field degree m of GF(3^m)
`define GF3M_M 97

// middle exponent k of the trinomial x^m + x^k + 2
`define GF3M_TAP 12

// trits of operand a folded in per clock
`define GF3M_STEP 3

`endif

// File: design/gf3m_pkg.sv
`include "gf3m_config.svh"

package gf3m_pkg;

    typedef logic [1:0] trit_t;                 // 00 = 0, 01 = 1, 10 = 2, 11 illegal
    typedef trit_t [`GF3M_M-1:0] elem_t;        // trit 0 is the constant term

    // number of horner steps, a is zero padded up to a whole digit
    localparam int GF3M_DIGITS = (`GF3M_M + `GF3M_STEP - 1) / `GF3M_STEP;

    typedef enum logic [1:0] {
        OP_MUL = 2'd0,
        OP_ADD = 2'd1,
        OP_SUB = 2'd2
    } gf3m_op_e;

    typedef struct packed {
        gf3m_op_e op;
        elem_t    a;
        elem_t    b;
    } gf3m_cmd_t;

    typedef struct packed {
        gf3m_op_e op;
        elem_t    result;
    } gf3m_rsp_t;

    typedef struct packed {
        logic load_a;     // digit register takes padded a
        logic load_b;
        logic clear_acc;
        logic step;       // one horner step
        logic add_ab;
        logic sub_ab;
    } pe_ctrl_t;

    function automatic trit_t trit_add(trit_t a, trit_t b);
        logic [2:0] s;
        s = 3'(a) + 3'(b);
        if (s >= 3'd3)
            s = s - 3'd3;
        return s[1:0];
    endfunction

    // swapping the two bits maps 1 <-> 2 and keeps 0
    function automatic trit_t trit_neg(trit_t a);
        return {a[0], a[1]};
    endfunction

    function automatic trit_t trit_mul(trit_t a, trit_t b);
        if (a == 2'd0 || b == 2'd0)
            return 2'd0;
        return (a == b) ? 2'd1 : 2'd2;    // 1*1 = 2*2 = 1, 1*2 = 2
    endfunction

endpackage

// File: design/gf3m_digit_step.sv
`timescale 1ns/1ps
`include "gf3m_config.svh"

module gf3m_digit_step (
    input  gf3m_pkg::elem_t                   acc,
    input  gf3m_pkg::elem_t                   b,
    input  gf3m_pkg::trit_t [`GF3M_STEP-1:0]  digits,   // digits[top] is most significant
    output gf3m_pkg::elem_t                   next
);
    import gf3m_pkg::*;

    // x * e mod (x^m + x^k + 2), using x^m = 2x^k + 1
    function automatic elem_t mul_x(elem_t e);
        elem_t r;
        trit_t top;
        top = e[`GF3M_M-1];
        r[0] = 2'd0;
        for (int i = 1; i < `GF3M_M; i++) begin
            r[i] = e[i-1];
        end
        r[0] = trit_add(r[0], top);                         // + top
        r[`GF3M_TAP] = trit_add(r[`GF3M_TAP], trit_neg(top)); // + 2*top
        return r;
    endfunction

    // partial product d * e, trit by trit
    function automatic elem_t elem_scale(elem_t e, trit_t d);
        elem_t r;
        for (int i = 0; i < `GF3M_M; i++) begin
            r[i] = trit_mul(d, e[i]);
        end
        return r;
    endfunction

    function automatic elem_t elem_add(elem_t p, elem_t q);
        elem_t r;
        for (int i = 0; i < `GF3M_M; i++) begin
            r[i] = trit_add(p[i], q[i]);
        end
        return r;
    endfunction

    // horner over the digit, most significant trit first:
    // acc*x^3 + d2*b*x^2 + d1*b*x + d0*b
    always_comb begin
        next = acc;
        for (int j = `GF3M_STEP-1; j >= 0; j--) begin
            next = elem_add(mul_x(next), elem_scale(b, digits[j]));
        end
    end

endmodule

// File: design/gf3m_pe.sv
`timescale 1ns/1ps
`include "gf3m_config.svh"

module gf3m_pe (
    input  logic               clk,
    input  logic               reset,
    input  gf3m_pkg::pe_ctrl_t ctrl,
    input  gf3m_pkg::elem_t    a_in,
    input  gf3m_pkg::elem_t    b_in,
    output gf3m_pkg::elem_t    acc
);
    import gf3m_pkg::*;

    localparam int PAD_TRITS = GF3M_DIGITS * `GF3M_STEP;

    typedef trit_t [PAD_TRITS-1:0] pad_t;

    pad_t  a_pad;
    pad_t  digit_q;      // shifts up one digit per step
    elem_t b_q;
    elem_t acc_q;
    elem_t step_next;
    elem_t sum_ab;
    elem_t diff_ab;

    always_comb begin
        a_pad = '0;                      // top trits stay zero
        a_pad[`GF3M_M-1:0] = a_in;
    end

    gf3m_digit_step u_digit_step (
        .acc    (acc_q),
        .b      (b_q),
        .digits (digit_q[PAD_TRITS-1 -: `GF3M_STEP]),
        .next   (step_next)
    );

    always_comb begin
        for (int i = 0; i < `GF3M_M; i++) begin
            sum_ab[i]  = trit_add(a_in[i], b_in[i]);
            diff_ab[i] = trit_add(a_in[i], trit_neg(b_in[i]));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            digit_q <= '0;
        end else if (ctrl.load_a) begin
            digit_q <= a_pad;
        end else if (ctrl.step) begin
            digit_q <= digit_q << (2 * `GF3M_STEP);   // next digit to the top
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            b_q <= '0;
        end else if (ctrl.load_b) begin
            b_q <= b_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            acc_q <= '0;
        end else if (ctrl.clear_acc) begin
            acc_q <= '0;
        end else if (ctrl.step) begin
            acc_q <= step_next;
        end else if (ctrl.add_ab) begin
            acc_q <= sum_ab;
        end else if (ctrl.sub_ab) begin
            acc_q <= diff_ab;
        end
    end

    assign acc = acc_q;

    function automatic logic has_illegal(elem_t e);
        logic bad;
        bad = 1'b0;
        for (int i = 0; i < `GF3M_M; i++) begin
            bad = bad | (e[i] == 2'b11);
        end
        return bad;
    endfunction

    // the sequencer must never request two accumulator updates at once
    a_one_acc_op : assert property (@(posedge clk) disable iff (reset)
        $onehot0({ctrl.step, ctrl.add_ab, ctrl.sub_ab}));

    // operands handed over by the sequencer carry legal trits only
    a_legal_operands : assert property (@(posedge clk) disable iff (reset)
        (ctrl.load_a || ctrl.add_ab) |-> !(has_illegal(a_in) || has_illegal(b_in)));

endmodule

// File: design/gf3m_sequencer.sv
`timescale 1ns/1ps

module gf3m_sequencer (
    input  logic                clk,
    input  logic                reset,
    input  logic                cmd_valid,
    input  gf3m_pkg::gf3m_cmd_t cmd,
    input  gf3m_pkg::elem_t     acc,
    output gf3m_pkg::pe_ctrl_t  ctrl,
    output gf3m_pkg::elem_t     a_in,
    output gf3m_pkg::elem_t     b_in,
    output logic                busy,
    output logic                rsp_valid,
    output gf3m_pkg::gf3m_rsp_t rsp
);
    import gf3m_pkg::*;

    localparam int CNT_W = $clog2(GF3M_DIGITS + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,    // load operands, or add / subtract
        ST_RUN,     // horner steps
        ST_EMIT     // acc is final, capture it
    } state_e;

    state_e           state;
    logic [CNT_W-1:0] digit_cnt;
    gf3m_cmd_t        cmd_q;
    logic             accept;
    logic             last_digit;

    assign accept     = cmd_valid && !busy && (state == ST_IDLE);
    assign last_digit = (digit_cnt == CNT_W'(GF3M_DIGITS - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_IDLE;
            digit_cnt <= '0;
            cmd_q     <= '0;
            busy      <= 1'b0;
            rsp_valid <= 1'b0;
            rsp       <= '0;
        end else begin
            rsp_valid <= 1'b0;               // one cycle strobe
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        cmd_q <= cmd;
                        busy  <= 1'b1;
                        state <= ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    digit_cnt <= '0;
                    state     <= (cmd_q.op == OP_MUL) ? ST_RUN : ST_EMIT;
                end
                ST_RUN: begin
                    digit_cnt <= digit_cnt + 1'b1;
                    if (last_digit)
                        state <= ST_EMIT;
                end
                ST_EMIT: begin
                    rsp.op     <= cmd_q.op;
                    rsp.result <= acc;
                    rsp_valid  <= 1'b1;
                    busy       <= 1'b0;     // low in the response cycle
                    state      <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_comb begin
        ctrl = '0;
        case (state)
            ST_LOAD: begin
                if (cmd_q.op == OP_MUL) begin
                    ctrl.load_a    = 1'b1;
                    ctrl.load_b    = 1'b1;
                    ctrl.clear_acc = 1'b1;
                end else if (cmd_q.op == OP_ADD) begin
                    ctrl.add_ab = 1'b1;
                end else begin
                    ctrl.sub_ab = 1'b1;
                end
            end
            ST_RUN:  ctrl.step = 1'b1;
            default: ctrl = '0;
        endcase
    end

    // operands only matter in the load cycle
    assign a_in = (state == ST_LOAD) ? cmd_q.a : '0;
    assign b_in = (state == ST_LOAD) ? cmd_q.b : '0;

    a_single_rsp : assert property (@(posedge clk) disable iff (reset)
        rsp_valid |=> !rsp_valid);

    // busy flag and FSM are kept in separate registers, they must agree
    a_idle_not_busy : assert property (@(posedge clk) disable iff (reset)
        (state == ST_IDLE) |-> !busy);

endmodule

// File: design/gf3m_unit.sv
`timescale 1ns/1ps

module gf3m_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                cmd_valid,
    input  gf3m_pkg::gf3m_cmd_t cmd,
    output logic                busy,
    output logic                rsp_valid,
    output gf3m_pkg::gf3m_rsp_t rsp
);
    import gf3m_pkg::*;

    pe_ctrl_t ctrl;      // sequencer to pe
    elem_t    a_in;
    elem_t    b_in;
    elem_t    acc;       // pe back to sequencer

    gf3m_sequencer u_sequencer (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .acc       (acc),
        .ctrl      (ctrl),
        .a_in      (a_in),
        .b_in      (b_in),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    gf3m_pe u_pe (
        .clk   (clk),
        .reset (reset),
        .ctrl  (ctrl),
        .a_in  (a_in),
        .b_in  (b_in),
        .acc   (acc)
    );

endmodule

// File: verification/tb_gf3m_unit.sv
`timescale 1ns/1ps
`include "gf3m_config.svh"

module tb_gf3m_unit;
    import gf3m_pkg::*;

    localparam int N_ADDSUB  = 50;              // per operation
    localparam int N_MUL     = 100;
    localparam int N_B2B     = 6;
    localparam int LAT_MUL   = GF3M_DIGITS + 2;
    localparam int LAT_ARITH = 2;
    // reset test costs about three commands, dropped test about two
    localparam int N_CMDS         = 2 * N_ADDSUB + N_MUL + 3 + N_B2B + 3 + 2;
    localparam int TIMEOUT_CYCLES = N_CMDS * (GF3M_DIGITS + 4) + 200;

    logic      clk;
    logic      reset;
    logic      cmd_valid;
    gf3m_cmd_t cmd;
    logic      busy;
    logic      rsp_valid;
    gf3m_rsp_t rsp;

    int        edge_cnt = 0;
    int        accept_edge;
    gf3m_rsp_t rsp_q[$];                        // filled by the monitor
    int        rsp_edge_q[$];
    int        total_checks = 0;
    int        total_errors = 0;
    int        tests_run = 0;
    int        tests_failed = 0;
    int        test_errors;
    string     test_name;

    gf3m_unit u_gf3m_unit (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) edge_cnt <= edge_cnt + 1;

    // response monitor, mid cycle so rsp is settled
    always @(negedge clk) begin
        if (!reset && rsp_valid) begin
            rsp_q.push_back(rsp);
            rsp_edge_q.push_back(edge_cnt);
        end
    end

    initial begin
        while (edge_cnt < TIMEOUT_CYCLES) begin
            @(negedge clk);
        end
        $display("timeout: the DUT stopped responding after %0d cycles", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    function automatic elem_t rand_elem();
        elem_t e;
        for (int i = 0; i < `GF3M_M; i++) begin
            e[i] = trit_t'($urandom % 3);        // legal trits only
        end
        return e;
    endfunction

    // schoolbook product, then fold x^m = 2x^k + 1 from the top down
    function automatic elem_t model_mul(elem_t a, elem_t b);
        trit_t prod [2*`GF3M_M-1];
        trit_t t;
        elem_t r;
        for (int i = 0; i < 2 * `GF3M_M - 1; i++) begin
            prod[i] = 2'd0;
        end
        for (int i = 0; i < `GF3M_M; i++) begin
            for (int j = 0; j < `GF3M_M; j++) begin
                prod[i+j] = trit_add(prod[i+j], trit_mul(a[i], b[j]));
            end
        end
        for (int i = 2 * `GF3M_M - 2; i >= `GF3M_M; i--) begin
            t = prod[i];
            prod[i] = 2'd0;
            prod[i-`GF3M_M] = trit_add(prod[i-`GF3M_M], t);
            prod[i-`GF3M_M+`GF3M_TAP] = trit_add(prod[i-`GF3M_M+`GF3M_TAP], trit_mul(2'd2, t));
        end
        for (int i = 0; i < `GF3M_M; i++) begin
            r[i] = prod[i];
        end
        return r;
    endfunction

    // add and subtract as plain integers mod 3
    function automatic elem_t model_result(gf3m_op_e op, elem_t a, elem_t b);
        elem_t r;
        int    s;
        if (op == OP_MUL)
            return model_mul(a, b);
        for (int i = 0; i < `GF3M_M; i++) begin
            if (op == OP_ADD)
                s = int'(a[i]) + int'(b[i]);
            else
                s = int'(a[i]) + 3 - int'(b[i]);
            r[i] = trit_t'(s % 3);
        end
        return r;
    endfunction

    task automatic compare_rsp(string what, gf3m_rsp_t expected, gf3m_rsp_t actual);
        total_checks++;
        if (expected !== actual) begin
            $display("FAIL %s: %s expected op %0d result %h, actual op %0d result %h",
                     test_name, what, expected.op, expected.result, actual.op, actual.result);
            total_errors++;
            test_errors++;
        end
    endtask

    task automatic compare_busy(string what, logic expected, logic actual);
        total_checks++;
        if (expected !== actual) begin
            $display("FAIL %s: %s expected %b, actual %b", test_name, what, expected, actual);
            total_errors++;
            test_errors++;
        end
    endtask

    task automatic compare_count(string what, int expected, int actual);
        total_checks++;
        if (expected != actual) begin
            $display("FAIL %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
            total_errors++;
            test_errors++;
        end
    endtask

    task automatic start_test(string name);
        test_name = name;
        test_errors = 0;
        rsp_q.delete();
        rsp_edge_q.delete();
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors != 0)
            tests_failed++;
        $display("test %-14s %s (%0d errors)", test_name,
                 (test_errors == 0) ? "ok" : "failed", test_errors);
    endtask

    // inputs move 2 ns after the rising edge
    task automatic tick(int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic issue(gf3m_op_e op, elem_t a, elem_t b);
        cmd_valid = 1'b1;
        cmd.op    = op;
        cmd.a     = a;
        cmd.b     = b;
        tick(1);
        cmd_valid   = 1'b0;
        accept_edge = edge_cnt;
    endtask

    task automatic wait_rsp(int n);
        while (rsp_q.size() < n) begin
            tick(1);
        end
    endtask

    task automatic run_one(string what, gf3m_op_e op, elem_t a, elem_t b, elem_t expected);
        gf3m_rsp_t want;
        gf3m_rsp_t got;
        want.op     = op;
        want.result = expected;
        rsp_q.delete();
        rsp_edge_q.delete();
        issue(op, a, b);
        wait_rsp(1);
        got = rsp_q.pop_front();
        compare_rsp(what, want, got);
        compare_count({what, " latency"}, (op == OP_MUL) ? LAT_MUL : LAT_ARITH,
                      rsp_edge_q.pop_front() - accept_edge);
    endtask

    initial begin
        elem_t     a;
        elem_t     b;
        elem_t     e;
        gf3m_op_e  op;
        gf3m_rsp_t want;
        gf3m_rsp_t got;
        gf3m_rsp_t exp_q[$];
        void'($urandom(94521));
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;

        start_test("reset");
        compare_busy("busy after reset", 1'b0, busy);
        compare_busy("rsp_valid after reset", 1'b0, rsp_valid);
        issue(OP_MUL, rand_elem(), rand_elem());
        tick(10);
        reset = 1'b1;                           // pulse in the middle of the multiply
        tick(2);
        reset = 1'b0;
        compare_busy("busy after reset pulse", 1'b0, busy);
        compare_busy("rsp_valid after reset pulse", 1'b0, rsp_valid);
        tick(LAT_MUL + 4);
        compare_count("responses of the aborted multiply", 0, rsp_q.size());
        a = rand_elem();
        b = rand_elem();
        run_one("mul after reset", OP_MUL, a, b, model_mul(a, b));
        finish_test();

        start_test("add_sub");
        for (int n = 0; n < 2 * N_ADDSUB; n++) begin
            op = (n % 2 == 0) ? OP_ADD : OP_SUB;
            a  = rand_elem();
            b  = rand_elem();
            run_one((op == OP_ADD) ? "add" : "sub", op, a, b, model_result(op, a, b));
        end
        finish_test();

        start_test("mul");
        for (int n = 0; n < N_MUL; n++) begin
            a = rand_elem();
            b = rand_elem();
            run_one("mul", OP_MUL, a, b, model_mul(a, b));
        end
        finish_test();

        start_test("identity");
        a    = rand_elem();
        b    = '0;
        b[0] = 2'd1;
        run_one("a times 1", OP_MUL, a, b, a);
        run_one("a times 0", OP_MUL, a, '0, '0);
        a = '0;
        a[`GF3M_M-1] = 2'd1;
        b    = '0;
        b[1] = 2'd1;
        e    = '0;
        e[0] = 2'd1;
        e[`GF3M_TAP] = 2'd2;                    // x^m = 2x^k + 1
        run_one("x^(m-1) times x", OP_MUL, a, b, e);
        finish_test();

        start_test("back_to_back");
        for (int n = 0; n < N_B2B; n++) begin
            op          = gf3m_op_e'(n % 3);
            a           = rand_elem();
            b           = rand_elem();
            want.op     = op;
            want.result = model_result(op, a, b);
            exp_q.push_back(want);
            if (n > 0) begin
                while (!rsp_valid) begin
                    tick(1);
                end
                compare_busy("busy in response cycle", 1'b0, busy);
            end
            issue(op, a, b);
        end
        wait_rsp(N_B2B);
        tick(LAT_MUL + 4);
        compare_count("responses", N_B2B, rsp_q.size());
        while (rsp_q.size() > 0 && exp_q.size() > 0) begin
            got = rsp_q.pop_front();
            compare_rsp("response in order", exp_q.pop_front(), got);
        end
        finish_test();

        start_test("dropped");
        a           = rand_elem();
        b           = rand_elem();
        want.op     = OP_MUL;
        want.result = model_mul(a, b);
        issue(OP_MUL, a, b);
        tick(3);
        for (int n = 0; n < 5; n++) begin
            compare_busy("busy while commands arrive", 1'b1, busy);
            cmd_valid = 1'b1;
            cmd.op    = OP_ADD;
            cmd.a     = rand_elem();
            cmd.b     = rand_elem();
            tick(1);
        end
        cmd_valid = 1'b0;
        wait_rsp(1);
        tick(LAT_MUL + 4);
        compare_count("responses with dropped commands", 1, rsp_q.size());
        got = rsp_q.pop_front();
        compare_rsp("running multiply", want, got);
        compare_count("running multiply latency", LAT_MUL, rsp_edge_q.pop_front() - accept_edge);
        finish_test();

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: gf3m_unit.f
+incdir+design
design/gf3m_pkg.sv
design/gf3m_digit_step.sv
design/gf3m_pe.sv
design/gf3m_sequencer.sv
design/gf3m_unit.sv
verification/tb_gf3m_unit.sv

// File: Makefile
TOP = tb_gf3m_unit
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): gf3m_unit.f design/*.sv design/*.svh verification/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f gf3m_unit.f -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
		echo "simulation reported failures"; exit 1; \
	fi

lint:
	verilator --lint-only -Wall +incdir+design --top-module gf3m_unit \
		design/gf3m_pkg.sv design/gf3m_digit_step.sv design/gf3m_pe.sv \
		design/gf3m_sequencer.sv design/gf3m_unit.sv

clean:
	rm -rf obj_dir $(LOG)
